// ==== raster_pkg.sv ====
package raster_pkg;

    // Screen size in pixels
    localparam int FB_W = 32;
    localparam int FB_H = 16;

    localparam int COORD_W = 16;
    localparam int DEPTH_W = 16;
    localparam int GRAD_W  = 16;

    // Coordinates and edge values share one signed width
    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic [DEPTH_W-1:0] depth_t;
    typedef logic signed [GRAD_W-1:0] grad_t;

    typedef enum logic [1:0] {
        SETUP_IDLE,
        SETUP_EDGES,
        SETUP_BUSY
    } setup_state_t;

    typedef enum logic [2:0] {
        TILE_IDLE,
        TILE_CLIP,
        TILE_INIT,
        TILE_DRAW,
        TILE_DONE
    } tile_state_t;

endpackage

// ==== tri_setup.sv ====
`timescale 1ns/1ps

module tri_setup #(
    parameter int NUM_TILES = 4,
    parameter int TILE_W = 8,
    parameter int FB_H = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  raster_pkg::coord_t x0,
    input  raster_pkg::coord_t y0,
    input  raster_pkg::coord_t x1,
    input  raster_pkg::coord_t y1,
    input  raster_pkg::coord_t x2,
    input  raster_pkg::coord_t y2,
    input  raster_pkg::depth_t z0,
    input  raster_pkg::grad_t dzdx,
    input  raster_pkg::grad_t dzdy,
    input  logic frame_done,
    output logic busy,
    output logic tri_valid,
    output raster_pkg::coord_t min_x,
    output raster_pkg::coord_t max_x,
    output raster_pkg::coord_t min_y,
    output raster_pkg::coord_t max_y,
    output raster_pkg::coord_t e0_start,
    output raster_pkg::coord_t e1_start,
    output raster_pkg::coord_t e2_start,
    output raster_pkg::coord_t e0_dx,
    output raster_pkg::coord_t e1_dx,
    output raster_pkg::coord_t e2_dx,
    output raster_pkg::coord_t e0_dy,
    output raster_pkg::coord_t e1_dy,
    output raster_pkg::coord_t e2_dy,
    output raster_pkg::depth_t z_start,
    output raster_pkg::grad_t dzdx_o,
    output raster_pkg::grad_t dzdy_o,
    output logic empty
);
    import raster_pkg::*;

    localparam int SCR_W = NUM_TILES * TILE_W;

    setup_state_t state;
    coord_t vx[3];
    coord_t vy[3];
    depth_t vz0;
    coord_t raw_lo_x;
    coord_t raw_hi_x;
    coord_t raw_lo_y;
    coord_t raw_hi_y;
    coord_t box_lo_x;
    coord_t box_hi_x;
    coord_t box_lo_y;
    coord_t box_hi_y;
    coord_t area;
    logic off_screen;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic coord_t clamp(input coord_t v, input coord_t hi);
        if (v < 0) begin
            return '0;
        end
        return (v > hi) ? hi : v;
    endfunction

    // Positive on the inner side of edge a->b for the positive winding
    function automatic coord_t edge_fn(input coord_t ax, ay, bx, by, px, py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    always_comb begin
        raw_lo_x = min3(vx[0], vx[1], vx[2]);
        raw_hi_x = max3(vx[0], vx[1], vx[2]);
        raw_lo_y = min3(vy[0], vy[1], vy[2]);
        raw_hi_y = max3(vy[0], vy[1], vy[2]);
        off_screen = (raw_hi_x < 0) || (raw_lo_x > coord_t'(SCR_W - 1)) ||
                     (raw_hi_y < 0) || (raw_lo_y > coord_t'(FB_H - 1));
        box_lo_x = clamp(raw_lo_x, coord_t'(SCR_W - 1));
        box_hi_x = clamp(raw_hi_x, coord_t'(SCR_W - 1));
        box_lo_y = clamp(raw_lo_y, coord_t'(FB_H - 1));
        box_hi_y = clamp(raw_hi_y, coord_t'(FB_H - 1));
        area = edge_fn(vx[0], vy[0], vx[1], vy[1], vx[2], vy[2]);
    end

    always_ff @(posedge clk) begin
        if (state == SETUP_IDLE && start) begin
            vx[0] <= x0;
            vy[0] <= y0;
            vx[1] <= x1;
            vy[1] <= y1;
            vx[2] <= x2;
            vy[2] <= y2;
            vz0 <= z0;
            dzdx_o <= dzdx;
            dzdy_o <= dzdy;
        end
        if (state == SETUP_EDGES) begin
            min_x <= box_lo_x;
            max_x <= box_hi_x;
            min_y <= box_lo_y;
            max_y <= box_hi_y;
            e0_start <= edge_fn(vx[0], vy[0], vx[1], vy[1], box_lo_x, box_lo_y);
            e1_start <= edge_fn(vx[1], vy[1], vx[2], vy[2], box_lo_x, box_lo_y);
            e2_start <= edge_fn(vx[2], vy[2], vx[0], vy[0], box_lo_x, box_lo_y);
            e0_dx <= vy[1] - vy[0];
            e1_dx <= vy[2] - vy[1];
            e2_dx <= vy[0] - vy[2];
            e0_dy <= vx[0] - vx[1];
            e1_dy <= vx[1] - vx[2];
            e2_dy <= vx[2] - vx[0];
            // Plane depth at the clamped corner, wraps to DEPTH_W
            z_start <= vz0 + depth_t'(dzdx_o * (box_lo_x - vx[0]))
                           + depth_t'(dzdy_o * (box_lo_y - vy[0]));
            empty <= off_screen || (area <= 0);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= SETUP_IDLE;
            tri_valid <= 1'b0;
        end else begin
            tri_valid <= (state == SETUP_EDGES);
            case (state)
                SETUP_IDLE: begin
                    if (start) begin
                        state <= SETUP_EDGES;
                    end
                end
                SETUP_EDGES: begin
                    state <= SETUP_BUSY;
                end
                SETUP_BUSY: begin
                    if (frame_done) begin
                        state <= SETUP_IDLE;
                    end
                end
                default: begin
                    state <= SETUP_IDLE;
                end
            endcase
        end
    end

    assign busy = (state != SETUP_IDLE);

    a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("start while a triangle is in flight");

endmodule

// ==== tile_raster.sv ====
`timescale 1ns/1ps

module tile_raster #(
    parameter int TILE_ID = 0,
    parameter int TILE_W = 8,
    parameter int FB_H = 16,
    localparam int ADDR_W = $clog2(TILE_W * FB_H)
) (
    input  logic clk,
    input  logic rst,
    input  logic tri_valid,
    input  logic empty,
    input  raster_pkg::coord_t min_x,
    input  raster_pkg::coord_t max_x,
    input  raster_pkg::coord_t min_y,
    input  raster_pkg::coord_t max_y,
    input  raster_pkg::coord_t e0_start,
    input  raster_pkg::coord_t e1_start,
    input  raster_pkg::coord_t e2_start,
    input  raster_pkg::coord_t e0_dx,
    input  raster_pkg::coord_t e1_dx,
    input  raster_pkg::coord_t e2_dx,
    input  raster_pkg::coord_t e0_dy,
    input  raster_pkg::coord_t e1_dy,
    input  raster_pkg::coord_t e2_dy,
    input  raster_pkg::depth_t z_start,
    input  raster_pkg::grad_t dzdx,
    input  raster_pkg::grad_t dzdy,
    output logic frag_we,
    output logic [ADDR_W-1:0] frag_addr,
    output raster_pkg::depth_t frag_depth,
    output logic tile_done
);
    import raster_pkg::*;

    // Columns owned by this tile
    localparam int STRIP_LO = TILE_ID * TILE_W;
    localparam int STRIP_HI = STRIP_LO + TILE_W - 1;

    tile_state_t state;
    coord_t clip_lo;
    coord_t clip_hi;
    logic clip_empty;
    coord_t x_lo;
    coord_t x_hi;
    coord_t off;
    coord_t x;
    coord_t y;
    logic last_px;
    coord_t e_start[3];
    coord_t e_dx[3];
    coord_t e_dy[3];
    coord_t e_val[3];
    coord_t e_row[3];
    depth_t z;
    depth_t z_row;

    always_comb begin
        e_start[0] = e0_start;
        e_start[1] = e1_start;
        e_start[2] = e2_start;
        e_dx[0] = e0_dx;
        e_dx[1] = e1_dx;
        e_dx[2] = e2_dx;
        e_dy[0] = e0_dy;
        e_dy[1] = e1_dy;
        e_dy[2] = e2_dy;
    end

    // Box limited to this strip
    always_comb begin
        clip_lo = (min_x > coord_t'(STRIP_LO)) ? min_x : coord_t'(STRIP_LO);
        clip_hi = (max_x < coord_t'(STRIP_HI)) ? max_x : coord_t'(STRIP_HI);
        clip_empty = (clip_lo > clip_hi);
    end

    assign off = x_lo - min_x;
    assign last_px = (x == x_hi) && (y == max_y);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TILE_IDLE;
        end else begin
            case (state)
                TILE_IDLE, TILE_DONE: begin
                    if (tri_valid) begin
                        state <= (empty || clip_empty) ? TILE_DONE : TILE_CLIP;
                    end
                end
                TILE_CLIP: begin
                    state <= TILE_INIT;
                end
                TILE_INIT: begin
                    state <= TILE_DRAW;
                end
                TILE_DRAW: begin
                    if (last_px) begin
                        state <= TILE_DONE;
                    end
                end
                default: begin
                    state <= TILE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            TILE_CLIP: begin
                x_lo <= clip_lo;
                x_hi <= clip_hi;
            end
            TILE_INIT: begin
                // Move from the box corner to the strip corner
                x <= x_lo;
                y <= min_y;
                z <= z_start + depth_t'(dzdx * off);
                z_row <= z_start + depth_t'(dzdx * off);
                for (int i = 0; i < 3; i++) begin
                    e_val[i] <= e_start[i] + e_dx[i] * off;
                    e_row[i] <= e_start[i] + e_dx[i] * off;
                end
            end
            TILE_DRAW: begin
                if (x < x_hi) begin
                    x <= x + coord_t'(1);
                    z <= z + depth_t'(dzdx);
                    for (int i = 0; i < 3; i++) begin
                        e_val[i] <= e_val[i] + e_dx[i];
                    end
                end else begin
                    // Next row restarts from the saved row start
                    x <= x_lo;
                    y <= y + coord_t'(1);
                    z <= z_row + depth_t'(dzdy);
                    z_row <= z_row + depth_t'(dzdy);
                    for (int i = 0; i < 3; i++) begin
                        e_val[i] <= e_row[i] + e_dy[i];
                        e_row[i] <= e_row[i] + e_dy[i];
                    end
                end
            end
            default: begin
            end
        endcase
    end

    assign frag_we = (state == TILE_DRAW) && (e_val[0] > 0) && (e_val[1] > 0) && (e_val[2] > 0);
    assign frag_addr = ADDR_W'(y * coord_t'(TILE_W) + (x - coord_t'(STRIP_LO)));
    assign frag_depth = z;
    assign tile_done = (state == TILE_IDLE) || (state == TILE_DONE);

    a_frag_in_strip: assert property (@(posedge clk) disable iff (rst)
        frag_we |-> (x >= coord_t'(STRIP_LO) && x <= coord_t'(STRIP_HI)))
        else $error("fragment outside strip of tile %0d", TILE_ID);

endmodule

// ==== depth_resolve.sv ====
`timescale 1ns/1ps

module depth_resolve #(
    parameter int NUM_TILES = 4,
    parameter int TILE_W = 8,
    parameter int FB_H = 16,
    localparam int ADDR_W = $clog2(TILE_W * FB_H)
) (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic tri_valid,
    input  logic [NUM_TILES-1:0] frag_we,
    input  logic [NUM_TILES*ADDR_W-1:0] frag_addr,
    input  logic [NUM_TILES*raster_pkg::DEPTH_W-1:0] frag_depth,
    input  logic [NUM_TILES-1:0] tile_done,
    input  raster_pkg::coord_t rd_x,
    input  raster_pkg::coord_t rd_y,
    output logic frame_done,
    output raster_pkg::depth_t rd_depth,
    output logic rd_valid
);
    import raster_pkg::*;

    localparam int BANK_SIZE = TILE_W * FB_H;
    localparam int BANK_W = (NUM_TILES > 1) ? $clog2(NUM_TILES) : 1;
    localparam int SCR_W = NUM_TILES * TILE_W;

    depth_t bank [NUM_TILES][BANK_SIZE];
    logic [BANK_SIZE-1:0] valid [NUM_TILES];
    logic armed;
    logic all_done;
    logic rd_on_screen;
    logic [BANK_W-1:0] rd_bank;
    logic [ADDR_W-1:0] rd_idx;

    for (genvar t = 0; t < NUM_TILES; t++) begin : g_bank
        logic [ADDR_W-1:0] addr;
        depth_t depth;
        logic wr;

        assign addr = frag_addr[t*ADDR_W +: ADDR_W];
        assign depth = frag_depth[t*DEPTH_W +: DEPTH_W];
        // Empty entries always accept the fragment
        assign wr = frag_we[t] && (!valid[t][addr] || depth < bank[t][addr]);

        always_ff @(posedge clk) begin
            if (wr) begin
                bank[t][addr] <= depth;
            end
        end

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                valid[t] <= '0;
            end else if (clear) begin
                valid[t] <= '0;
            end else if (wr) begin
                valid[t][addr] <= 1'b1;
            end
        end
    end

    assign all_done = &tile_done;

    // One frame_done per triangle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= armed && all_done;
            if (tri_valid) begin
                armed <= 1'b1;
            end else if (armed && all_done) begin
                armed <= 1'b0;
            end
        end
    end

    // Screen column to bank and strip-local index
    always_comb begin
        rd_on_screen = (rd_x >= 0) && (rd_x < coord_t'(SCR_W)) &&
                       (rd_y >= 0) && (rd_y < coord_t'(FB_H));
        rd_bank = BANK_W'(rd_x / coord_t'(TILE_W));
        rd_idx = ADDR_W'(rd_y * coord_t'(TILE_W) + rd_x % coord_t'(TILE_W));
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_on_screen && valid[rd_bank][rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rd_on_screen) begin
            rd_depth <= bank[rd_bank][rd_idx];
        end
    end

    a_clear_no_write: assert property (@(posedge clk) disable iff (rst)
        clear |-> (frag_we == '0))
        else $error("clear during fragment writes");

endmodule

// ==== raster_top.sv ====
`timescale 1ns/1ps

module raster_top #(
    parameter int NUM_TILES = 4,
    parameter int TILE_W = raster_pkg::FB_W / NUM_TILES,
    parameter int FB_H = raster_pkg::FB_H
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  raster_pkg::coord_t x0,
    input  raster_pkg::coord_t y0,
    input  raster_pkg::coord_t x1,
    input  raster_pkg::coord_t y1,
    input  raster_pkg::coord_t x2,
    input  raster_pkg::coord_t y2,
    input  raster_pkg::depth_t z0,
    input  raster_pkg::grad_t dzdx,
    input  raster_pkg::grad_t dzdy,
    input  logic clear,
    input  raster_pkg::coord_t rd_x,
    input  raster_pkg::coord_t rd_y,
    output logic busy,
    output logic done,
    output raster_pkg::depth_t rd_depth,
    output logic rd_valid
);
    import raster_pkg::*;

    localparam int ADDR_W = $clog2(TILE_W * FB_H);

    // Triangle broadcast from setup
    logic tri_valid;
    logic empty;
    coord_t min_x;
    coord_t max_x;
    coord_t min_y;
    coord_t max_y;
    coord_t e0_start;
    coord_t e1_start;
    coord_t e2_start;
    coord_t e0_dx;
    coord_t e1_dx;
    coord_t e2_dx;
    coord_t e0_dy;
    coord_t e1_dy;
    coord_t e2_dy;
    depth_t z_start;
    grad_t dzdx_o;
    grad_t dzdy_o;

    // Per-tile fragment streams
    logic [NUM_TILES-1:0] frag_we;
    logic [NUM_TILES*ADDR_W-1:0] frag_addr;
    logic [NUM_TILES*DEPTH_W-1:0] frag_depth;
    logic [NUM_TILES-1:0] tile_done;

    tri_setup #(
        .NUM_TILES(NUM_TILES),
        .TILE_W(TILE_W),
        .FB_H(FB_H)
    ) u_setup (
        .frame_done(done),
        .*
    );

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        // Tiles take the latched gradients
        tile_raster #(
            .TILE_ID(i),
            .TILE_W(TILE_W),
            .FB_H(FB_H)
        ) u_tile (
            .dzdx(dzdx_o),
            .dzdy(dzdy_o),
            .frag_we(frag_we[i]),
            .frag_addr(frag_addr[i*ADDR_W +: ADDR_W]),
            .frag_depth(frag_depth[i*DEPTH_W +: DEPTH_W]),
            .tile_done(tile_done[i]),
            .*
        );
    end

    depth_resolve #(
        .NUM_TILES(NUM_TILES),
        .TILE_W(TILE_W),
        .FB_H(FB_H)
    ) u_resolve (
        .frame_done(done),
        .*
    );

endmodule

// ==== tb_raster.sv ====
`timescale 1ns/1ps

module tb_raster;
    import raster_pkg::*;

    localparam int DONE_LIMIT = 2000;
    localparam int SCAN_LIMIT = 4000;

    logic clk = 1'b0;
    logic rst;
    logic start;
    coord_t x0;
    coord_t y0;
    coord_t x1;
    coord_t y1;
    coord_t x2;
    coord_t y2;
    depth_t z0;
    grad_t dzdx;
    grad_t dzdy;
    logic clear;
    coord_t rd_x;
    coord_t rd_y;
    logic busy;
    logic done;
    depth_t rd_depth;
    logic rd_valid;

    // Expected screen since the last clear
    depth_t ref_depth [FB_W][FB_H];
    logic ref_valid [FB_W][FB_H];

    // Triangle currently being drawn
    int vert_x [3];
    int vert_y [3];
    int plane_z0;
    int plane_gx;
    int plane_gy;

    logic [31:0] lfsr;
    int scans_req = 0;
    int scans_done = 0;
    string scan_name;

    raster_top DUT (.*);

    always #50 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_depth(input string name, input depth_t exp, input depth_t act);
        if (act !== exp) begin
            fail_run($sformatf("Fail %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("Fail %s expected %b actual %b", name, exp, act));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = (val << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic int edge_at(input int ax, input int ay, input int bx, input int by,
                                   input int px, input int py);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic logic pixel_covered(input int px, input int py);
        return (edge_at(vert_x[0], vert_y[0], vert_x[1], vert_y[1], px, py) > 0) &&
               (edge_at(vert_x[1], vert_y[1], vert_x[2], vert_y[2], px, py) > 0) &&
               (edge_at(vert_x[2], vert_y[2], vert_x[0], vert_y[0], px, py) > 0);
    endfunction

    // Plane through vertex 0, wrapped to the depth width
    function automatic depth_t plane_depth(input int px, input int py);
        int z;
        z = plane_z0 + plane_gx * (px - vert_x[0]) + plane_gy * (py - vert_y[0]);
        return depth_t'(z);
    endfunction

    task automatic update_model();
        depth_t d;
        for (int x = 0; x < FB_W; x++) begin
            for (int y = 0; y < FB_H; y++) begin
                if (pixel_covered(x, y)) begin
                    d = plane_depth(x, y);
                    if (!ref_valid[x][y] || d < ref_depth[x][y]) begin
                        ref_depth[x][y] = d;
                        ref_valid[x][y] = 1'b1;
                    end
                end
            end
        end
    endtask

    task automatic clear_screen();
        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        for (int x = 0; x < FB_W; x++) begin
            for (int y = 0; y < FB_H; y++) begin
                ref_valid[x][y] = 1'b0;
                ref_depth[x][y] = '0;
            end
        end
    endtask

    // Hands the readback to the comparing process and waits for it
    task automatic scan(input string name);
        int n;
        scan_name = name;
        @(posedge clk);
        scans_req <= scans_req + 1;
        @(posedge clk);
        n = 0;
        while (scans_done != scans_req) begin
            @(posedge clk);
            n++;
            if (n > SCAN_LIMIT) begin
                fail_run($sformatf("%s: screen readback never finished", name));
            end
        end
    endtask

    task automatic draw(input string name, input int ax, input int ay, input int bx,
                        input int by, input int cx, input int cy, input int z,
                        input int gx, input int gy);
        int n;
        vert_x[0] = ax;
        vert_y[0] = ay;
        vert_x[1] = bx;
        vert_y[1] = by;
        vert_x[2] = cx;
        vert_y[2] = cy;
        plane_z0 = z;
        plane_gx = gx;
        plane_gy = gy;
        @(posedge clk);
        x0 <= coord_t'(ax);
        y0 <= coord_t'(ay);
        x1 <= coord_t'(bx);
        y1 <= coord_t'(by);
        x2 <= coord_t'(cx);
        y2 <= coord_t'(cy);
        z0 <= depth_t'(z);
        dzdx <= grad_t'(gx);
        dzdy <= grad_t'(gy);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_valid($sformatf("%s busy", name), 1'b1, busy);
        n = 1;
        while (!done) begin
            @(negedge clk);
            n++;
            if (n > DONE_LIMIT) begin
                fail_run($sformatf("%s: done never came after start", name));
            end
        end
        if (n < 4) begin
            fail_run($sformatf("%s: done came only %0d cycles after start", name, n));
        end
        update_model();
        scan(name);
    endtask

    task automatic draw_random(input int idx);
        int v [6];
        int t;
        int z;
        int gx;
        int gy;
        for (int k = 0; k < 3; k++) begin
            take_bits(6, t);
            v[2*k] = t - 12;
            take_bits(5, t);
            v[2*k+1] = t - 8;
        end
        take_bits(16, z);
        take_bits(8, gx);
        take_bits(8, gy);
        // Turn most triangles front facing, zero area stays as drawn
        if (edge_at(v[0], v[1], v[2], v[3], v[4], v[5]) < 0) begin
            t = v[2];
            v[2] = v[4];
            v[4] = t;
            t = v[3];
            v[3] = v[5];
            v[5] = t;
        end
        draw($sformatf("random %0d", idx), v[0], v[1], v[2], v[3], v[4], v[5],
             z, gx - 128, gy - 128);
    endtask

    // Registered read port, one pixel every two cycles
    task automatic read_screen();
        string tag;
        int off_x [3] = '{-1, 32, 5};
        int off_y [3] = '{3, 0, 16};
        for (int y = 0; y < FB_H; y++) begin
            for (int x = 0; x < FB_W; x++) begin
                @(posedge clk);
                rd_x <= coord_t'(x);
                rd_y <= coord_t'(y);
                @(posedge clk);
                @(negedge clk);
                tag = $sformatf("%s pixel (%0d,%0d)", scan_name, x, y);
                check_valid($sformatf("%s valid", tag), ref_valid[x][y], rd_valid);
                if (ref_valid[x][y]) begin
                    check_depth($sformatf("%s depth", tag), ref_depth[x][y], rd_depth);
                end
            end
        end
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            rd_x <= coord_t'(off_x[k]);
            rd_y <= coord_t'(off_y[k]);
            @(posedge clk);
            @(negedge clk);
            tag = $sformatf("%s off screen (%0d,%0d) valid", scan_name, off_x[k], off_y[k]);
            check_valid(tag, 1'b0, rd_valid);
        end
    endtask

    // Comparing process
    initial begin
        rd_x <= '0;
        rd_y <= '0;
        forever begin
            @(posedge clk);
            if (scans_done != scans_req) begin
                read_screen();
                scans_done <= scans_req;
            end
        end
    end

    initial begin
        rst <= 1'b1;
        start <= 1'b0;
        x0 <= '0;
        y0 <= '0;
        x1 <= '0;
        y1 <= '0;
        x2 <= '0;
        y2 <= '0;
        z0 <= '0;
        dzdx <= '0;
        dzdy <= '0;
        clear <= 1'b0;
        lfsr = 32'h80c07175;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        clear_screen();
        @(negedge clk);
        check_valid("idle busy", 1'b0, busy);
        check_valid("idle done", 1'b0, done);
        scan("after clear");

        draw("ccw wide", 1, 1, 3, 14, 30, 4, 16'h1000, 5, -3);

        // Both of these leave the screen as it was
        draw("cw wide", 1, 1, 30, 4, 3, 14, 16'h0100, 0, 0);
        draw("degenerate", 0, 0, 10, 5, 20, 10, 16'h0000, 0, 0);

        clear_screen();
        draw("a then b, a", 2, 2, 6, 15, 28, 6, 16'h2000, 40, 0);
        draw("a then b, b", 0, 8, 26, 14, 31, 0, 16'h2400, -30, 10);
        clear_screen();
        draw("b then a, b", 0, 8, 26, 14, 31, 0, 16'h2400, -30, 10);
        draw("b then a, a", 2, 2, 6, 15, 28, 6, 16'h2000, 40, 0);
        draw("equal depth", 2, 2, 6, 15, 28, 6, 16'h2000, 40, 0);

        clear_screen();
        draw("partly off", -10, -5, 5, 30, 45, 8, 16'hff00, 100, -200);
        draw("off right", 40, 2, 42, 10, 50, 3, 16'h0000, 0, 0);
        draw("off top", 2, -10, 5, -2, 12, -8, 16'h0000, 0, 0);

        for (int g = 0; g < 4; g++) begin
            clear_screen();
            for (int i = 0; i < 10; i++) begin
                draw_random(g * 10 + i);
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
raster_pkg.sv
tri_setup.sv
tile_raster.sv
depth_resolve.sv
raster_top.sv
tb_raster.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_raster
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -qx "Finished with no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
